// File: icache_pkg.sv
package icache_pkg;

  // ----------------------------------------
  // Cache geometry
  // ----------------------------------------
  // Two ways, 256 sets, 32-byte lines
  localparam int NUM_WAYS    = 2;
  localparam int LINE_ADDR_W = 8;
  localparam int LINE_OFFS_W = 5;
  // 32-bit AXI beats per line
  localparam int LINE_BEATS  = 8;

  // AXI burst type INCR
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [31:0]            addr_t;
  typedef logic [31:0]            word_t;
  typedef logic [63:0]            inst_t;
  // PC[12:5]
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  // PC[31:13]
  typedef logic [18:0]            tag_t;
  // PC[12:3], one 64-bit row
  typedef logic [9:0]             data_addr_t;
  typedef logic [2:0]             beat_idx_t;
  typedef logic [0:0]             way_t;

  // Controller states
  typedef enum logic [1:0] {
    FLUSH,
    LOOKUP,
    REFILL,
    RELOOKUP
  } state_e;

  // ----------------------------------------
  // Packed structs
  // ----------------------------------------
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // Fetch side request strobes and PC
  typedef struct packed {
    logic  rd;
    logic  flush;
    logic  invalidate;
    addr_t pc;
  } fetch_req_t;

  // AXI read address channel
  typedef struct packed {
    logic        valid;
    addr_t       addr;
    logic [3:0]  id;
    logic [7:0]  len;
    logic [1:0]  burst;
  } axi_ar_t;

  // AXI read data channel
  typedef struct packed {
    logic       valid;
    word_t      data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

endpackage

// File: icache_tag_ram.sv
`timescale 1ns/1ps

module icache_tag_ram
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  line_addr_t addr_i,
  input  tag_entry_t data_i,
  input  logic       wr_i,
  output tag_entry_t data_o
);

  // One tag entry per set
  tag_entry_t mem_q [2**$bits(line_addr_t)];

  // Write port
  always_ff @(posedge clk_i)
  begin
    if (wr_i)
      mem_q[addr_i] <= data_i;
  end

  // Registered read, written entry shows on the next cycle
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      data_o <= '0;
    else if (wr_i)
      data_o <= data_i;
    else
      data_o <= mem_q[addr_i];
  end

endmodule

// File: icache_data_ram.sv
`timescale 1ns/1ps

module icache_data_ram
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  data_addr_t addr_i,
  input  inst_t      data_i,
  input  logic       wr_i,
  output inst_t      data_o
);

  // 1024 rows of 64 bits, four rows per line
  inst_t mem_q [2**$bits(data_addr_t)];

  // Write port
  always_ff @(posedge clk_i)
  begin
    if (wr_i)
      mem_q[addr_i] <= data_i;
  end

  // Registered read, write data passes through
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      data_o <= '0;
    else if (wr_i)
      data_o <= data_i;
    else
      data_o <= mem_q[addr_i];
  end

endmodule

// File: icache_way.sv
`timescale 1ns/1ps

module icache_way
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // Tag store port
  input  line_addr_t tag_addr_i,
  input  tag_entry_t tag_data_i,
  input  logic       tag_wr_i,
  // Data store port
  input  data_addr_t data_addr_i,
  input  inst_t      data_i,
  input  logic       data_wr_i,
  // Tag of the registered lookup
  input  tag_t       cmp_tag_i,
  output logic       hit_o,
  output inst_t      inst_o
);

  tag_entry_t tag_q;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  icache_tag_ram u_tag (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .addr_i (tag_addr_i),
    .data_i (tag_data_i),
    .wr_i   (tag_wr_i),
    .data_o (tag_q)
  );

  icache_data_ram u_data (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .addr_i (data_addr_i),
    .data_i (data_i),
    .wr_i   (data_wr_i),
    .data_o (inst_o)
  );

  // ----------------------------------------
  // Tag compare
  // ----------------------------------------
  // Stored tag only counts when the entry is valid
  assign hit_o = tag_q.valid && (tag_q.tag == cmp_tag_i);

endmodule

// File: icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  fetch_req_t          req_i,
  input  logic [NUM_WAYS-1:0] hit_i,
  input  logic                line_done_i,
  input  way_t                replace_way_i,
  input  data_addr_t          refill_addr_i,
  output logic                req_accept_o,
  output logic                req_valid_o,
  output logic                refill_start_o,
  output addr_t               lookup_addr_o,
  output line_addr_t          tag_addr_o,
  output tag_entry_t          tag_data_o,
  output logic [NUM_WAYS-1:0] tag_wr_o,
  output data_addr_t          data_addr_o,
  output tag_t                cmp_tag_o
);

  // Lowest tag bit, and byte offset of a 64-bit row
  localparam int TAG_LSB     = LINE_ADDR_W + LINE_OFFS_W;
  localparam int INST_OFFS_W = 3;

  state_e     state_q;
  state_e     state_d;
  logic       lookup_valid_q;
  addr_t      lookup_addr_q;
  line_addr_t flush_addr_q;
  logic       invalidate_q;
  logic       any_hit;
  line_addr_t req_line;
  data_addr_t req_row;
  line_addr_t lookup_line;
  data_addr_t lookup_row;

  // Address fields of incoming PC and of held lookup
  assign req_line    = req_i.pc[TAG_LSB-1:LINE_OFFS_W];
  assign req_row     = req_i.pc[TAG_LSB-1:INST_OFFS_W];
  assign lookup_line = lookup_addr_q[TAG_LSB-1:LINE_OFFS_W];
  assign lookup_row  = lookup_addr_q[TAG_LSB-1:INST_OFFS_W];
  assign cmp_tag_o   = lookup_addr_q[31:TAG_LSB];

  assign lookup_addr_o = lookup_addr_q;
  assign any_hit       = |hit_i;

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      FLUSH:
      begin
        // Single set for invalidate, else walk to last set
        if (invalidate_q || flush_addr_q == '1)
          state_d = LOOKUP;
      end
      LOOKUP:
      begin
        // Miss takes priority over maintenance strobes
        if (lookup_valid_q && !any_hit)
          state_d = REFILL;
        else if (req_i.invalidate || req_i.flush)
          state_d = FLUSH;
      end
      REFILL:
      begin
        if (line_done_i)
          state_d = RELOOKUP;
      end
      default:
        state_d = LOOKUP;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= FLUSH;
    else
      state_q <= state_d;
  end

  // Fetch side strobes
  assign req_accept_o   = (state_q == LOOKUP) && (state_d != REFILL);
  assign req_valid_o    = lookup_valid_q && (state_q == LOOKUP) && any_hit;
  assign refill_start_o = (state_q == LOOKUP) && (state_d == REFILL);

  // ----------------------------------------
  // Lookup registers
  // ----------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      lookup_valid_q <= 1'b0;
    else if (req_i.rd && req_accept_o)
      lookup_valid_q <= 1'b1;
    else if (req_valid_o)
      lookup_valid_q <= 1'b0;
  end

  // PC held for compare, refill and relookup
  always_ff @(posedge clk_i)
  begin
    if (req_i.rd && req_accept_o)
      lookup_addr_q <= req_i.pc;
  end

  // ----------------------------------------
  // Flush / invalidate counter
  // ----------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      flush_addr_q <= '0;
    else if (state_q == FLUSH)
      flush_addr_q <= flush_addr_q + 1'b1;
    else if (req_i.invalidate && req_accept_o)
      flush_addr_q <= req_line;
    else
      flush_addr_q <= '0;
  end

  // Marks a one-set flush
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      invalidate_q <= 1'b0;
    else
      invalidate_q <= req_i.invalidate && req_accept_o;
  end

  // ----------------------------------------
  // RAM address and tag write muxing
  // ----------------------------------------
  always_comb
  begin
    tag_addr_o = req_line;
    tag_data_o = '0;
    tag_wr_o   = '0;
    case (state_q)
      FLUSH:
      begin
        // Cleared entry into every way
        tag_addr_o = flush_addr_q;
        tag_wr_o   = '1;
      end
      REFILL:
      begin
        // Valid entry into replacement way on last beat
        tag_addr_o               = lookup_line;
        tag_data_o.valid         = 1'b1;
        tag_data_o.tag           = cmp_tag_o;
        tag_wr_o[replace_way_i]  = line_done_i;
      end
      RELOOKUP:
        tag_addr_o = lookup_line;
      default:
        tag_addr_o = req_line;
    endcase
  end

  always_comb
  begin
    case (state_q)
      REFILL:   data_addr_o = refill_addr_i;
      RELOOKUP: data_addr_o = lookup_row;
      default:  data_addr_o = req_row;
    endcase
  end

endmodule

// File: icache_refill.sv
`timescale 1ns/1ps

module icache_refill
  import icache_pkg::*;
#(
  parameter int AXI_ID = 0
)
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                refill_start_i,
  input  addr_t               lookup_addr_i,
  input  logic                ar_ready_i,
  input  axi_r_t              r_i,
  input  logic                fetch_valid_i,
  output axi_ar_t             ar_o,
  output logic                r_ready_o,
  output logic                line_done_o,
  output way_t                replace_way_o,
  output data_addr_t          refill_addr_o,
  output inst_t               refill_data_o,
  output logic [NUM_WAYS-1:0] data_wr_o,
  output logic                error_o
);

  // Row field of a line-aligned address
  localparam int ROW_MSB = LINE_ADDR_W + LINE_OFFS_W - 1;

  logic      ar_hold_q;
  beat_idx_t beat_q;
  word_t     lower_q;
  way_t      replace_q;
  logic      beat;

  assign beat = r_i.valid && r_ready_o;

  // ----------------------------------------
  // AR channel
  // ----------------------------------------
  // Raised with the start pulse, held until arready
  assign ar_o.valid = refill_start_i || ar_hold_q;
  assign ar_o.addr  = {lookup_addr_i[31:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
  assign ar_o.id    = 4'(AXI_ID);
  assign ar_o.len   = 8'(LINE_BEATS - 1);
  assign ar_o.burst = AXI_BURST_INCR;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ar_hold_q <= 1'b0;
    else
      ar_hold_q <= ar_o.valid && !ar_ready_i;
  end

  // No back-pressure on read data
  assign r_ready_o = 1'b1;

  // ----------------------------------------
  // Beat packing
  // ----------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      beat_q <= '0;
    else if (beat && r_i.last)
      beat_q <= '0;
    else if (beat)
      beat_q <= beat_q + 1'b1;
  end

  // Previous beat becomes low half of the row
  always_ff @(posedge clk_i)
  begin
    if (beat)
      lower_q <= r_i.data;
  end

  assign refill_data_o = {r_i.data, lower_q};

  // Row pointer, starts at line base, steps after odd beats
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      refill_addr_o <= '0;
    else if (refill_start_i)
      refill_addr_o <= ar_o.addr[ROW_MSB:3];
    else if (beat && beat_q[0])
      refill_addr_o <= refill_addr_o + 1'b1;
  end

  // Even beats write half rows, odd beats complete them
  always_comb
  begin
    data_wr_o = '0;
    data_wr_o[replace_q] = beat;
  end

  assign line_done_o = beat && r_i.last;

  // ----------------------------------------
  // Replacement toggle
  // ----------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      replace_q <= '0;
    else if (line_done_o)
      replace_q <= ~replace_q;
  end

  assign replace_way_o = replace_q;

  // ----------------------------------------
  // Sticky fetch error
  // ----------------------------------------
  // Any non-OKAY beat, cleared once the fetch completes
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      error_o <= 1'b0;
    else if (beat && r_i.resp != 2'b00)
      error_o <= 1'b1;
    else if (fetch_valid_i)
      error_o <= 1'b0;
  end

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache
  import icache_pkg::*;
#(
  parameter int AXI_ID = 0
)
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  fetch_req_t req_i,
  input  logic       ar_ready_i,
  input  axi_r_t     r_i,
  output logic       req_accept_o,
  output logic       req_valid_o,
  output logic       req_error_o,
  output inst_t      req_inst_o,
  output axi_ar_t    ar_o,
  output logic       r_ready_o
);

  logic [NUM_WAYS-1:0] hit;
  inst_t               way_inst [NUM_WAYS];
  logic                refill_start;
  addr_t               lookup_addr;
  logic                line_done;
  way_t                replace_way;
  data_addr_t          refill_addr;
  inst_t               refill_data;
  logic [NUM_WAYS-1:0] data_wr;
  line_addr_t          tag_addr;
  tag_entry_t          tag_data;
  logic [NUM_WAYS-1:0] tag_wr;
  data_addr_t          data_addr;
  tag_t                cmp_tag;

  // ----------------------------------------
  // Controller and refill engine
  // ----------------------------------------
  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .hit_i          (hit),
    .line_done_i    (line_done),
    .replace_way_i  (replace_way),
    .refill_addr_i  (refill_addr),
    .req_accept_o   (req_accept_o),
    .req_valid_o    (req_valid_o),
    .refill_start_o (refill_start),
    .lookup_addr_o  (lookup_addr),
    .tag_addr_o     (tag_addr),
    .tag_data_o     (tag_data),
    .tag_wr_o       (tag_wr),
    .data_addr_o    (data_addr),
    .cmp_tag_o      (cmp_tag)
  );

  icache_refill #(
    .AXI_ID (AXI_ID)
  ) u_refill (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .refill_start_i (refill_start),
    .lookup_addr_i  (lookup_addr),
    .ar_ready_i     (ar_ready_i),
    .r_i            (r_i),
    .fetch_valid_i  (req_valid_o),
    .ar_o           (ar_o),
    .r_ready_o      (r_ready_o),
    .line_done_o    (line_done),
    .replace_way_o  (replace_way),
    .refill_addr_o  (refill_addr),
    .refill_data_o  (refill_data),
    .data_wr_o      (data_wr),
    .error_o        (req_error_o)
  );

  // ----------------------------------------
  // Ways
  // ----------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    icache_way u_way (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .tag_addr_i  (tag_addr),
      .tag_data_i  (tag_data),
      .tag_wr_i    (tag_wr[w]),
      .data_addr_i (data_addr),
      .data_i      (refill_data),
      .data_wr_i   (data_wr[w]),
      .cmp_tag_i   (cmp_tag),
      .hit_o       (hit[w]),
      .inst_o      (way_inst[w])
    );
  end

  // Fetch word from the hitting way, way 0 if none
  always_comb
  begin
    req_inst_o = way_inst[0];
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (hit[w])
        req_inst_o = way_inst[w];
    end
  end

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem
  import icache_pkg::*;
#(
  parameter addr_t ERR_LINE = 32'h0
)
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  input  logic    r_ready_i,
  output axi_r_t  r_o
);

  // Each word reads back as its address XOR this mask
  localparam word_t      DATA_MASK   = 32'h5A5A_0000;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  integer     seed = 67;
  logic       busy_q;
  logic [1:0] delay_q;
  addr_t      addr_q;
  logic [7:0] len_q;
  logic [7:0] beat_q;
  logic       err_q;

  // Random arready delay of 0 to 3 cycles
  function automatic logic [1:0] draw_delay();
    integer r;
    r = $random(seed);
    return r[1:0];
  endfunction

  // ----------------------------------------
  // Address and burst handling
  // ----------------------------------------
  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ar_ready_o <= 1'b0;
      r_o        <= '0;
      busy_q     <= 1'b0;
      delay_q    <= draw_delay();
      addr_q     <= '0;
      len_q      <= '0;
      beat_q     <= '0;
      err_q      <= 1'b0;
    end
    else if (!busy_q)
    begin
      if (ar_i.valid && ar_ready_o)
      begin
        // Address taken, first beat next cycle
        ar_ready_o <= 1'b0;
        busy_q     <= 1'b1;
        addr_q     <= ar_i.addr;
        len_q      <= ar_i.len;
        beat_q     <= '0;
        err_q      <= (ar_i.addr[31:LINE_OFFS_W] == ERR_LINE[31:LINE_OFFS_W]);
      end
      else if (ar_i.valid && delay_q == 2'd0)
        ar_ready_o <= 1'b1;
      else if (ar_i.valid)
        delay_q <= delay_q - 2'd1;
    end
    else if (!r_o.valid || r_ready_i)
    begin
      if (r_o.valid && r_o.last)
      begin
        // Burst over, new wait for next address
        r_o     <= '0;
        busy_q  <= 1'b0;
        delay_q <= draw_delay();
      end
      else
      begin
        r_o.valid <= 1'b1;
        r_o.data  <= addr_q ^ DATA_MASK;
        r_o.resp  <= err_q ? RESP_SLVERR : RESP_OKAY;
        r_o.last  <= (beat_q == len_q);
        addr_q    <= addr_q + 32'd4;
        beat_q    <= beat_q + 8'd1;
      end
    end
  end

endmodule

// File: tb_icache.sv
`timescale 1ns/1ps

module tb_icache
  import icache_pkg::*;
();

  // Lines A, B and C share set 8
  // Line E answers with SLVERR
  localparam addr_t LINE_A      = 32'h0000_0100;
  localparam addr_t LINE_B      = 32'h0000_2100;
  localparam addr_t LINE_C      = 32'h0000_4100;
  localparam addr_t LINE_D      = 32'h0000_0600;
  localparam addr_t LINE_E      = 32'h0000_8200;
  localparam addr_t LINE_G      = 32'h0000_0300;
  localparam word_t DATA_MASK   = 32'h5A5A_0000;
  localparam int    CYCLE_LIMIT = 200;
  localparam int    FLUSH_LIMIT = 1000;

  typedef enum logic [1:0] {
    OP_FETCH,
    OP_FLUSH,
    OP_INVAL
  } op_e;

  typedef struct packed {
    op_e   op;
    addr_t pc;
    logic  refill;
    logic  err;
  } op_entry_t;

  logic       clk_i;
  logic       rst_i;
  fetch_req_t req;
  logic       req_accept;
  logic       req_valid;
  logic       req_error;
  inst_t      req_inst;
  axi_ar_t    ar;
  logic       ar_ready;
  axi_r_t     r;
  logic       r_ready;
  op_entry_t  ops [$];
  int         ar_count = 0;
  axi_ar_t    ar_last;
  int         test_errs = 0;
  int         pass_count = 0;
  int         fail_count = 0;

  icache #(
    .AXI_ID (3)
  ) dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req),
    .ar_ready_i   (ar_ready),
    .r_i          (r),
    .req_accept_o (req_accept),
    .req_valid_o  (req_valid),
    .req_error_o  (req_error),
    .req_inst_o   (req_inst),
    .ar_o         (ar),
    .r_ready_o    (r_ready)
  );

  tb_axi_mem #(
    .ERR_LINE (LINE_E)
  ) u_mem (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_ready_i  (r_ready),
    .r_o        (r)
  );

  // 100 ns clock
  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // AR handshakes counted at the falling edge
  always @(negedge clk_i)
  begin
    if (ar.valid && ar_ready)
    begin
      ar_count <= ar_count + 1;
      ar_last  <= ar;
    end
    // Read data never stalled
    if (r.valid)
      compare_value("r_ready_o", 64'(r_ready), 64'd1);
  end

  // ----------------------------------------
  // Expected data and checking
  // ----------------------------------------
  // Word at aligned+4 sits above word at aligned
  function automatic inst_t expected_inst(input addr_t pc);
    addr_t base;
    base = {pc[31:3], 3'b000};
    return {(base + 32'd4) ^ DATA_MASK, base ^ DATA_MASK};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Result: FAILED");
    $finish;
  endtask

  // Counts negedges up to and including the one that shows accept high
  task automatic wait_accept(input int limit, input string what, output int cycles);
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while (!req_accept && cycles < limit);
    if (!req_accept)
      stop_on_timeout(what);
  endtask

  // ----------------------------------------
  // Operations
  // ----------------------------------------
  task automatic run_fetch(input op_entry_t e);
    int start_count;
    int n;
    start_count = ar_count;
    @(posedge clk_i);
    req.rd <= 1'b1;
    req.pc <= e.pc;
    wait_accept(CYCLE_LIMIT, "fetch request never accepted", n);
    @(posedge clk_i);
    req.rd <= 1'b0;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!req_valid && n < CYCLE_LIMIT);
    if (!req_valid)
      stop_on_timeout("fetch never returned req_valid_o");
    else
    begin
      compare_value("req_inst_o", req_inst, expected_inst(e.pc));
      compare_value("req_error_o", 64'(req_error), 64'(e.err));
      compare_value("AR handshake count", 64'(ar_count - start_count), 64'(e.refill));
      if (e.refill)
      begin
        compare_value("ar_o.addr", 64'(ar_last.addr), 64'({e.pc[31:5], 5'b0}));
        compare_value("ar_o.len", 64'(ar_last.len), 64'd7);
        // AXI INCR burst code
        compare_value("ar_o.burst", 64'(ar_last.burst), 64'd1);
        compare_value("ar_o.id", 64'(ar_last.id), 64'd3);
      end
    end
  endtask

  // Flush or invalidate, then wait for the walk to end
  task automatic run_maint(input op_entry_t e);
    int n;
    @(posedge clk_i);
    req.flush      <= (e.op == OP_FLUSH);
    req.invalidate <= (e.op == OP_INVAL);
    req.pc         <= e.pc;
    wait_accept(CYCLE_LIMIT, "maintenance request never accepted", n);
    @(posedge clk_i);
    req.flush      <= 1'b0;
    req.invalidate <= 1'b0;
    wait_accept(FLUSH_LIMIT, "req_accept_o stuck low after maintenance", n);
  endtask

  task automatic build_table();
    // First fill and same-line hits
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A + 32'h08, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A + 32'h08, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A + 32'h10, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A + 32'h18, 1'b0, 1'b0});
    // Second way of set 8, then C evicts A
    ops.push_back(op_entry_t'{OP_FETCH, LINE_B, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_B + 32'h18, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_C + 32'h10, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_B, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_C, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_C, 1'b0, 1'b0});
    // Single set clear hits both ways
    ops.push_back(op_entry_t'{OP_INVAL, LINE_A, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_C, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_D, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_D + 32'h08, 1'b0, 1'b0});
    // Whole cache flush
    ops.push_back(op_entry_t'{OP_FLUSH, 32'h0, 1'b0, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_A, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_D, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_C, 1'b1, 1'b0});
    // Error line, then good line clears the flag
    ops.push_back(op_entry_t'{OP_FETCH, LINE_E + 32'h08, 1'b1, 1'b1});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_G, 1'b1, 1'b0});
    ops.push_back(op_entry_t'{OP_FETCH, LINE_E, 1'b0, 1'b0});
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    int cycles;
    rst_i = 1'b1;
    req   = '0;
    build_table();
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    // Outputs quiet while in reset
    compare_value("req_accept_o", 64'(req_accept), 64'd0);
    compare_value("req_valid_o", 64'(req_valid), 64'd0);
    compare_value("req_error_o", 64'(req_error), 64'd0);
    compare_value("ar_o.valid", 64'(ar.valid), 64'd0);
    @(posedge clk_i);
    rst_i <= 1'b0;
    // Flush walk of 256 sets before the first accept
    wait_accept(FLUSH_LIMIT, "req_accept_o never rose after reset", cycles);
    compare_value("flush cycles", 64'(cycles - 1), 64'd256);
    if (test_errs == 0)
      pass_count++;
    else
      fail_count++;
    $display("Test reset flush: %s", (test_errs == 0) ? "ok" : "failed");
    foreach (ops[i])
    begin
      test_errs = 0;
      if (ops[i].op == OP_FETCH)
        run_fetch(ops[i]);
      else
        run_maint(ops[i]);
      if (test_errs == 0)
        pass_count++;
      else
        fail_count++;
      $display("Test %0d %s pc %h: %s", i, ops[i].op.name(), ops[i].pc,
               (test_errs == 0) ? "ok" : "failed");
    end
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: icache.f
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_way.sv
icache_ctrl.sv
icache_refill.sv
icache.sv
tb_axi_mem.sv
tb_icache.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -j 0 --top-module tb_icache -f icache.f
	./obj_dir/Vtb_icache | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Pass message not found in $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
